/* axi_read_ram.sv */
module axi_read_ram (
  input  logic             clock,
  input  logic             reset,
  input  mem_pkg::ar_req_t ar,
  input  logic             arvalid,
  output logic             arready,
  output mem_pkg::r_beat_t r,
  output logic             rvalid,
  input  logic             rready
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_beat
  } state_t;

  state_t            state;
  ar_req_t           req;
  logic [lat_w-1:0]  lat_cnt;
  logic [7:0]        beats_left;
  logic [addr_w-3:0] word_addr;
  logic              beat_ok;
  logic [data_w-1:0] mem [ram_words];

  initial begin
    for (int i = 0; i < ram_words; i++) begin
      mem[i] = ram_word_value(i);
    end
  end

  assign arready = (state == st_idle); // one burst at a time
  assign rvalid  = (state == st_beat);

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      lat_cnt    <= '0;
      beats_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (arvalid) begin
            state      <= st_wait;
            lat_cnt    <= lat_w'(ram_latency - 1);
            beats_left <= ar.len;
          end
        end
        st_wait: begin
          if (lat_cnt == '0) state <= st_beat;
          else lat_cnt <= lat_cnt - 1'b1;
        end
        st_beat: begin
          if (rready) begin
            if (beats_left == 8'd0) state <= st_idle;
            else beats_left <= beats_left - 8'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && arvalid) begin
      req       <= ar;
      word_addr <= ar.addr[addr_w-1:2];
    end else if (state == st_beat && rready && beats_left != 8'd0) begin
      if (req.burst == burst_incr) word_addr <= word_addr + 1'b1; // fixed stays put
    end
  end

  // range is checked per beat, an incr burst can run off the end
  assign beat_ok = (word_addr < (addr_w - 2)'(ram_words)) && (req.size == size_word);

  always_comb begin
    r.data = beat_ok ? mem[word_addr[ram_idx_w-1:0]] : '0;
    r.resp = beat_ok ? resp_okay : resp_slverr;
    r.last = (beats_left == 8'd0);
    r.id   = req.id;
  end

endmodule

/* mem_pkg.sv */
package mem_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int id_w   = 4;

  localparam logic [1:0] burst_fixed = 2'd0;
  localparam logic [1:0] burst_incr  = 2'd1;

  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

  localparam logic [2:0] size_word = 3'd2; // 4 bytes per beat

  localparam int ram_words   = 1024;
  localparam int ram_idx_w   = $clog2(ram_words);
  localparam int ram_latency = 3; // ar handshake to first beat
  localparam int lat_w       = $clog2(ram_latency + 1);

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [id_w-1:0]   id;
    logic [7:0]        len;   // beats minus one
    logic [2:0]        size;
    logic [1:0]        burst;
  } ar_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [1:0]        resp;
    logic              last;
    logic [id_w-1:0]   id;
  } r_beat_t;

  // fill pattern of the memory, one word per index
  function automatic logic [data_w-1:0] ram_word_value(input logic [31:0] idx);
    logic [data_w-1:0] v;
    v = idx * 32'h9e37_79b1;
    return v ^ 32'h5a3c_c3a5;
  endfunction

endpackage

/* mem_read_checker.sv */
module mem_read_checker (
  input logic             clock,
  input logic             reset,
  input logic             ifu_rvalid,
  input logic             lsu_rvalid,
  input logic             ram_arvalid,
  input logic             ram_arready,
  input mem_pkg::r_beat_t ram_r,
  input logic             ram_rvalid,
  input logic             ram_rready
);
  logic busy; // ram has a burst, last beat not yet taken

  always_ff @(posedge clock) begin
    if (reset) busy <= 1'b0;
    else if (ram_arvalid && ram_arready) busy <= 1'b1;
    else if (ram_rvalid && ram_rready && ram_r.last) busy <= 1'b0;
  end

  // each ram beat reaches exactly one master
  one_master_rvalid: assert property (@(posedge clock) disable iff (reset)
    ram_rvalid == (ifu_rvalid ^ lsu_rvalid))
    else $error("ram beat not routed to exactly one master");

  beat_held: assert property (@(posedge clock) disable iff (reset)
    ram_rvalid && !ram_rready |=> ram_rvalid && $stable(ram_r))
    else $error("ram beat changed while stalled");

  no_ar_in_burst: assert property (@(posedge clock) disable iff (reset)
    busy |-> !ram_arvalid)
    else $error("ram arvalid raised during a burst");

endmodule

bind read_arbiter mem_read_checker u_checker (.*);

/* mem_subsystem.sv */
module mem_subsystem (
  input  logic             clock,
  input  logic             reset,

  input  mem_pkg::ar_req_t ifu_ar,
  input  logic             ifu_arvalid,
  output logic             ifu_arready,
  output mem_pkg::r_beat_t ifu_r,
  output logic             ifu_rvalid,
  input  logic             ifu_rready,

  input  mem_pkg::ar_req_t lsu_ar,
  input  logic             lsu_arvalid,
  output logic             lsu_arready,
  output mem_pkg::r_beat_t lsu_r,
  output logic             lsu_rvalid,
  input  logic             lsu_rready
);
  import mem_pkg::*;

  ar_req_t ram_ar;
  logic    ram_arvalid;
  logic    ram_arready;
  r_beat_t ram_r;
  logic    ram_rvalid;
  logic    ram_rready;

  read_arbiter u_arbiter (
    .clock       (clock),
    .reset       (reset),
    .ifu_ar      (ifu_ar),
    .ifu_arvalid (ifu_arvalid),
    .ifu_arready (ifu_arready),
    .ifu_r       (ifu_r),
    .ifu_rvalid  (ifu_rvalid),
    .ifu_rready  (ifu_rready),
    .lsu_ar      (lsu_ar),
    .lsu_arvalid (lsu_arvalid),
    .lsu_arready (lsu_arready),
    .lsu_r       (lsu_r),
    .lsu_rvalid  (lsu_rvalid),
    .lsu_rready  (lsu_rready),
    .ram_ar      (ram_ar),
    .ram_arvalid (ram_arvalid),
    .ram_arready (ram_arready),
    .ram_r       (ram_r),
    .ram_rvalid  (ram_rvalid),
    .ram_rready  (ram_rready)
  );

  axi_read_ram u_ram (
    .clock   (clock),
    .reset   (reset),
    .ar      (ram_ar),
    .arvalid (ram_arvalid),
    .arready (ram_arready),
    .r       (ram_r),
    .rvalid  (ram_rvalid),
    .rready  (ram_rready)
  );

endmodule

/* read_arbiter.sv */
module read_arbiter (
  input  logic             clock,
  input  logic             reset,

  input  mem_pkg::ar_req_t ifu_ar,
  input  logic             ifu_arvalid,
  output logic             ifu_arready,
  output mem_pkg::r_beat_t ifu_r,
  output logic             ifu_rvalid,
  input  logic             ifu_rready,

  input  mem_pkg::ar_req_t lsu_ar,
  input  logic             lsu_arvalid,
  output logic             lsu_arready,
  output mem_pkg::r_beat_t lsu_r,
  output logic             lsu_rvalid,
  input  logic             lsu_rready,

  output mem_pkg::ar_req_t ram_ar,
  output logic             ram_arvalid,
  input  logic             ram_arready,
  input  mem_pkg::r_beat_t ram_r,
  input  logic             ram_rvalid,
  output logic             ram_rready
);
  import mem_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_ifu,
    st_lsu,
    st_hold_req,
    st_hold_resp
  } state_t;

  state_t  state;
  state_t  state_next;
  logic    held;      // ifu request waiting behind an lsu burst
  logic    held_next;
  ar_req_t held_req;
  logic    idle_hs;
  logic    both_req;
  logic    burst_done;

  assign idle_hs    = (state == st_idle) && ram_arready;
  assign both_req   = ifu_arvalid && lsu_arvalid;
  assign burst_done = ram_rvalid && ram_rready && ram_r.last;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      held  <= 1'b0;
    end else begin
      state <= state_next;
      held  <= held_next;
    end
  end

  // whole ifu request, not just the address
  always_ff @(posedge clock) begin
    if (idle_hs && both_req) held_req <= ifu_ar;
  end

  always_comb begin
    state_next = state;
    held_next  = held;
    case (state)
      st_idle: begin
        if (ram_arready) begin
          if (both_req) begin
            state_next = st_lsu;
            held_next  = 1'b1;
          end else if (lsu_arvalid) begin
            state_next = st_lsu;
          end else if (ifu_arvalid) begin
            state_next = st_ifu;
          end
        end
      end
      st_ifu: begin
        if (burst_done) state_next = st_idle;
      end
      st_lsu: begin
        if (burst_done) state_next = held ? st_hold_req : st_idle;
      end
      st_hold_req: begin
        if (ram_arready) begin
          state_next = st_hold_resp;
          held_next  = 1'b0;
        end
      end
      st_hold_resp: begin
        if (burst_done) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

  assign ifu_arready = idle_hs;
  assign lsu_arready = idle_hs;

  always_comb begin
    ram_arvalid = 1'b0;
    ram_ar      = '0;
    case (state)
      st_idle: begin
        ram_arvalid = ifu_arvalid || lsu_arvalid;
        ram_ar      = lsu_arvalid ? lsu_ar : ifu_ar; // lsu first
      end
      st_hold_req: begin
        ram_arvalid = 1'b1;
        ram_ar      = held_req;
      end
      default: ;
    endcase
  end

  always_comb begin
    ram_rready = 1'b0;
    ifu_rvalid = 1'b0;
    lsu_rvalid = 1'b0;
    case (state)
      st_lsu: begin
        ram_rready = lsu_rready;
        lsu_rvalid = ram_rvalid;
      end
      st_ifu, st_hold_resp: begin
        ram_rready = ifu_rready;
        ifu_rvalid = ram_rvalid;
      end
      default: ;
    endcase
  end

  // beat payload fans out, only rvalid selects the master
  assign ifu_r = ram_r;
  assign lsu_r = ram_r;

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_mem_subsystem -f sources.f -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem

/* sources.f */
mem_pkg.sv
read_arbiter.sv
axi_read_ram.sv
mem_subsystem.sv
mem_read_checker.sv
tb_mem_subsystem.sv

/* tb_mem_subsystem.sv */
module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int rand_count     = 100; // per master
  localparam int directed_beats = 4 + 12 + 12 + 3 + 7;

  logic    clock;
  logic    reset;
  ar_req_t ifu_ar;
  logic    ifu_arvalid;
  logic    ifu_arready;
  r_beat_t ifu_r;
  logic    ifu_rvalid;
  logic    ifu_rready;
  ar_req_t lsu_ar;
  logic    lsu_arvalid;
  logic    lsu_arready;
  r_beat_t lsu_r;
  logic    lsu_rvalid;
  logic    lsu_rready;

  r_beat_t ifu_q[$];
  r_beat_t lsu_q[$];
  ar_req_t ifu_rand[rand_count];
  ar_req_t lsu_rand[rand_count];
  string   test_name;
  bit      rready_random;
  bit      lsu_first;   // ifu beats must wait for the lsu burst
  int      cycles;
  int      cycle_limit;

  mem_subsystem uut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // expected beat n of a burst, from the memory fill rule and the error rule
  function automatic r_beat_t expected_beat(input ar_req_t req, input int n);
    logic [29:0] word;
    r_beat_t     b;
    word = req.addr[31:2];
    if (req.burst == burst_incr) word = word + 30'(n);
    b.id   = req.id;
    b.last = (n == int'(req.len));
    if (word < 30'(ram_words) && req.size == size_word) begin
      b.data = ram_word_value({2'b00, word});
      b.resp = resp_okay;
    end else begin
      b.data = '0;
      b.resp = resp_slverr;
    end
    return b;
  endfunction

  function automatic ar_req_t make_req(input logic [31:0] addr, input logic [7:0] len,
                                       input logic [1:0] burst, input logic [2:0] size,
                                       input logic [3:0] id);
    ar_req_t req;
    req.addr  = addr;
    req.len   = len;
    req.burst = burst;
    req.size  = size;
    req.id    = id;
    return req;
  endfunction

  function automatic ar_req_t random_req();
    logic [31:0] addr;
    addr = {20'd0, 10'($urandom_range(1023, 0)), 2'b00};
    if ($urandom_range(15, 0) == 0) addr = addr + 32'h1000; // past the end
    return make_req(addr, 8'($urandom_range(7, 0)),
                    ($urandom_range(1, 0) != 0) ? burst_incr : burst_fixed,
                    ($urandom_range(15, 0) == 0) ? 3'd1 : size_word, 4'($urandom));
  endfunction

  task automatic abort_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %s: expected %0h actual %0h", what, exp, act);
      abort_run("a checked value did not match");
    end
  endtask

  task automatic compare_beat(input string what, input r_beat_t exp, input r_beat_t act);
    check({what, " data"}, 64'(exp.data), 64'(act.data));
    check({what, " resp"}, 64'(exp.resp), 64'(act.resp));
    check({what, " last"}, 64'(exp.last), 64'(act.last));
    check({what, " id"}, 64'(exp.id), 64'(act.id));
  endtask

  // holds valid until the handshake, then queues the expected beats
  task automatic issue(input bit to_lsu, input ar_req_t req);
    @(posedge clock);
    if (to_lsu) begin
      lsu_ar      <= req;
      lsu_arvalid <= 1'b1;
    end else begin
      ifu_ar      <= req;
      ifu_arvalid <= 1'b1;
    end
    do @(negedge clock); while (to_lsu ? !lsu_arready : !ifu_arready);
    for (int n = 0; n <= int'(req.len); n++) begin
      if (to_lsu) lsu_q.push_back(expected_beat(req, n));
      else ifu_q.push_back(expected_beat(req, n));
    end
    @(posedge clock);
    if (to_lsu) lsu_arvalid <= 1'b0;
    else ifu_arvalid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (ifu_q.size() != 0 || lsu_q.size() != 0) @(posedge clock);
    @(posedge clock);
  endtask

  always @(posedge clock) begin
    ifu_rready <= rready_random ? 1'($urandom_range(1, 0)) : 1'b1;
    lsu_rready <= rready_random ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  // beats are taken at the next rising edge, so sample them here
  always @(negedge clock) begin
    if (ifu_rvalid && ifu_rready) begin
      if (ifu_q.size() == 0) begin
        abort_run("the ifu port returned a beat that no request asked for");
      end else begin
        if (lsu_first) check({test_name, " lsu left"}, 64'd0, 64'(lsu_q.size()));
        compare_beat({test_name, " ifu"}, ifu_q.pop_front(), ifu_r);
      end
    end
    if (lsu_rvalid && lsu_rready) begin
      if (lsu_q.size() == 0) abort_run("the lsu port returned a beat that no request asked for");
      else compare_beat({test_name, " lsu"}, lsu_q.pop_front(), lsu_r);
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) abort_run($sformatf("the run timed out after %0d cycles", cycles));
  end

  initial begin
    int rand_beats;
    void'($urandom(32'ha159af1a));
    reset         <= 1'b1;
    ifu_ar        <= '0;
    ifu_arvalid   <= 1'b0;
    ifu_rready    <= 1'b1;
    lsu_ar        <= '0;
    lsu_arvalid   <= 1'b0;
    lsu_rready    <= 1'b1;
    rready_random = 1'b0;
    lsu_first     = 1'b0;
    cycles        = 0;
    rand_beats    = 0;
    for (int i = 0; i < rand_count; i++) begin
      ifu_rand[i] = random_req();
      lsu_rand[i] = random_req();
      rand_beats += int'(ifu_rand[i].len) + int'(lsu_rand[i].len) + 2;
    end
    cycle_limit = 20 * (directed_beats + rand_beats) + 500;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    test_name = "after reset";
    check({test_name, " ifu arready"}, 64'd1, 64'(ifu_arready));
    check({test_name, " lsu arready"}, 64'd1, 64'(lsu_arready));
    check({test_name, " rvalid"}, 64'd0, 64'(ifu_rvalid || lsu_rvalid));

    test_name = "ifu single";
    issue(1'b0, make_req(32'h0000_0000, 8'd0, burst_incr, size_word, 4'h1));
    issue(1'b0, make_req(32'h0000_0ffc, 8'd0, burst_incr, size_word, 4'h2)); // last word
    issue(1'b0, make_req(32'h0000_0400, 8'd0, burst_incr, size_word, 4'h3));
    issue(1'b0, make_req(32'h0000_07c4, 8'd0, burst_fixed, size_word, 4'h4));
    wait_drain();

    test_name = "lsu incr";
    rready_random = 1'b1;
    issue(1'b1, make_req(32'h0000_0100, 8'd3, burst_incr, size_word, 4'h5));
    issue(1'b1, make_req(32'h0000_02a0, 8'd3, burst_incr, size_word, 4'h6));
    issue(1'b1, make_req(32'h0000_03f0, 8'd3, burst_incr, size_word, 4'h7));
    wait_drain();

    test_name = "same cycle";
    rready_random = 1'b0;
    lsu_first     = 1'b1;
    for (int k = 0; k < 2; k++) begin
      fork
        issue(1'b1, make_req(32'h0000_0800 + 32'(k * 64), 8'd3, burst_incr, size_word, 4'h8));
        issue(1'b0, make_req(32'h0000_0040 + 32'(k * 8), 8'd1,
                             (k == 0) ? burst_incr : burst_fixed, size_word, 4'(9 + k)));
      join
      // ifu taken together with the lsu, so no lsu beat is out yet
      check({test_name, " lsu pending"}, 64'd4, 64'(lsu_q.size()));
      wait_drain();
    end
    lsu_first = 1'b0;

    test_name = "fixed burst";
    issue(1'b0, make_req(32'h0000_048c, 8'd2, burst_fixed, size_word, 4'hb));
    wait_drain();

    test_name = "slverr";
    issue(1'b1, make_req(32'h0000_1000, 8'd3, burst_incr, size_word, 4'hc));
    issue(1'b1, make_req(32'h0000_0010, 8'd1, burst_incr, 3'd1, 4'hd)); // halfword size
    issue(1'b0, make_req(32'h2000_0000, 8'd0, burst_incr, size_word, 4'he));
    wait_drain();

    test_name = "random mix";
    rready_random = 1'b1;
    fork
      for (int i = 0; i < rand_count; i++) begin
        repeat ($urandom_range(3, 0)) @(posedge clock);
        issue(1'b0, ifu_rand[i]);
      end
      for (int j = 0; j < rand_count; j++) begin
        repeat ($urandom_range(3, 0)) @(posedge clock);
        issue(1'b1, lsu_rand[j]);
      end
    join
    wait_drain();
    $display("Test completed successfully");
    $finish;
  end

endmodule
